// ==== design/isa_bus_pkg.sv ====
`default_nettype none

package isa_bus_pkg;

	// 8088 address and data bus widths
	localparam int ADDR_W = 20;
	localparam int DATA_W = 8;

	// one bus cycle kind per clock
	// interrupt acknowledge wins over any other strobe
	typedef enum logic [2:0] {
		CYC_IDLE   = 3'd0,
		CYC_IO_RD  = 3'd1,
		CYC_IO_WR  = 3'd2,
		CYC_MEM_RD = 3'd3,
		CYC_MEM_WR = 3'd4,
		CYC_INTA   = 3'd5
	} bus_cycle_t;

endpackage

`default_nettype wire

// ==== design/io_map_pkg.sv ====
`default_nettype none

package io_map_pkg;

	// device claimed by the current bus cycle
	typedef enum logic [3:0] {
		DEV_NONE     = 4'd0,
		DEV_DMA      = 4'd1,
		DEV_PIC      = 4'd2,
		DEV_PIT      = 4'd3,
		DEV_PPI      = 4'd4,
		DEV_DMA_PAGE = 4'd5,
		DEV_LPT      = 4'd6,
		DEV_VRAM     = 4'd7,
		DEV_RAM      = 4'd8
	} dev_sel_t;

	// printer data latch, full 16-bit port
	localparam logic [15:0] LPT_PORT = 16'h0378;

	// B8000h window, address bits 19:15
	localparam logic [4:0] VRAM_BASE_HI = 5'b10111;

	// on-board chips in 0x000-0x0ff, one 32-port block each on bits 7:5
	// slot order is dma, pic, pit, ppi, dma page
	localparam logic [4:0][2:0] BOARD_IO_BLOCK = {
		3'd4,
		3'd3,
		3'd2,
		3'd1,
		3'd0
	};

	// nobody answers this memory read
	localparam logic [7:0] OPEN_BUS = 8'hFF;

endpackage

`default_nettype wire

// ==== design/bus_decode_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module bus_decode_stage
	import isa_bus_pkg::*;
	import io_map_pkg::*;
#(
	parameter int VRAM_AW = 14
) (
	input  logic               clock,
	input  logic               reset,
	input  logic [ADDR_W-1:0]  address_i,
	input  logic [DATA_W-1:0]  data_i,
	input  logic               io_read_n_i,
	input  logic               io_write_n_i,
	input  logic               memory_read_n_i,
	input  logic               memory_write_n_i,
	input  logic               address_enable_n_i,
	input  logic               interrupt_acknowledge_n_i,
	output logic               dma_cs_n_o,
	output logic               dma_page_cs_n_o,
	output logic               pic_cs_n_o,
	output logic               pit_cs_n_o,
	output logic               ppi_cs_n_o,
	output bus_cycle_t         cycle_o,
	output dev_sel_t           device_o,
	output logic [VRAM_AW-1:0] address_o,
	output logic [DATA_W-1:0]  data_o
);

	bus_cycle_t cycle_kind;
	dev_sel_t   device_sel;
	logic       io_cycle;
	logic       mem_cycle;
	logic       board_io;

	// strobes to one cycle kind, inta first
	always_comb begin
		if (!interrupt_acknowledge_n_i)
			cycle_kind = CYC_INTA;
		else if (!io_read_n_i)
			cycle_kind = CYC_IO_RD;
		else if (!io_write_n_i)
			cycle_kind = CYC_IO_WR;
		else if (!memory_read_n_i)
			cycle_kind = CYC_MEM_RD;
		else if (!memory_write_n_i)
			cycle_kind = CYC_MEM_WR;
		else
			cycle_kind = CYC_IDLE;
	end

	assign io_cycle  = (cycle_kind == CYC_IO_RD) || (cycle_kind == CYC_IO_WR);
	assign mem_cycle = (cycle_kind == CYC_MEM_RD) || (cycle_kind == CYC_MEM_WR);

	// cpu owns the bus and port is below 0x100
	assign board_io = io_cycle && !address_enable_n_i && (address_i[9:8] == 2'b00);

	// address to one device
	always_comb begin
		device_sel = DEV_NONE;
		if (board_io) begin
			if (address_i[7:5] == BOARD_IO_BLOCK[0])
				device_sel = DEV_DMA;
			else if (address_i[7:5] == BOARD_IO_BLOCK[1])
				device_sel = DEV_PIC;
			else if (address_i[7:5] == BOARD_IO_BLOCK[2])
				device_sel = DEV_PIT;
			else if (address_i[7:5] == BOARD_IO_BLOCK[3])
				device_sel = DEV_PPI;
			else if (address_i[7:5] == BOARD_IO_BLOCK[4])
				device_sel = DEV_DMA_PAGE;
		end else if (io_cycle && (address_i[15:0] == LPT_PORT)) begin
			device_sel = DEV_LPT;
		end else if (mem_cycle && (address_i[19:15] == VRAM_BASE_HI)) begin
			device_sel = DEV_VRAM;
		end else if (mem_cycle && !address_i[19]) begin
			device_sel = DEV_RAM;
		end
	end

	// external chip selects, same cycle
	assign dma_cs_n_o      = (device_sel != DEV_DMA);
	assign pic_cs_n_o      = (device_sel != DEV_PIC);
	assign pit_cs_n_o      = (device_sel != DEV_PIT);
	assign ppi_cs_n_o      = (device_sel != DEV_PPI);
	assign dma_page_cs_n_o = (device_sel != DEV_DMA_PAGE);

	// edge 1, cycle and device
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			cycle_o  <= CYC_IDLE;
			device_o <= DEV_NONE;
		end else begin
			cycle_o  <= cycle_kind;
			device_o <= device_sel;
		end
	end

	// window offset and write data ride along
	always_ff @(posedge clock) begin
		address_o <= address_i[VRAM_AW-1:0];
		data_o    <= data_i;
	end

endmodule

`default_nettype wire

// ==== design/device_access_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module device_access_stage
	import isa_bus_pkg::*;
	import io_map_pkg::*;
#(
	parameter int VRAM_AW = 14
) (
	input  logic               clock,
	input  logic               reset,
	input  bus_cycle_t         cycle_i,
	input  dev_sel_t           device_i,
	input  logic [VRAM_AW-1:0] address_i,
	input  logic [DATA_W-1:0]  data_i,
	output bus_cycle_t         cycle_o,
	output dev_sel_t           device_o,
	output logic [DATA_W-1:0]  read_data_o
);

	localparam int VRAM_DEPTH = 2 ** VRAM_AW;

	logic [DATA_W-1:0] lpt_data;
	logic [DATA_W-1:0] vram [VRAM_DEPTH];
	logic              lpt_write;
	logic              vram_write;

	assign lpt_write  = (cycle_i == CYC_IO_WR) && (device_i == DEV_LPT);
	assign vram_write = (cycle_i == CYC_MEM_WR) && (device_i == DEV_VRAM);

	// printer latch, idles at all ones
	always_ff @(posedge clock or posedge reset) begin
		if (reset)
			lpt_data <= 8'hFF;
		else if (lpt_write)
			lpt_data <= data_i;
	end

	// cpu port of the video ram
	// smaller VRAM_AW just mirrors inside the 32k window
	always_ff @(posedge clock) begin
		if (vram_write)
			vram[address_i] <= data_i;
	end

	// read fetch at edge 2
	// a write one cycle earlier has already landed here
	always_ff @(posedge clock) begin
		if (device_i == DEV_LPT)
			read_data_o <= lpt_data;
		else
			read_data_o <= vram[address_i];
	end

	// cycle and device follow the data
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			cycle_o  <= CYC_IDLE;
			device_o <= DEV_NONE;
		end else begin
			cycle_o  <= cycle_i;
			device_o <= device_i;
		end
	end

endmodule

`default_nettype wire

// ==== design/read_return_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module read_return_stage
	import isa_bus_pkg::*;
	import io_map_pkg::*;
(
	input  logic              clock,
	input  logic              reset,
	input  bus_cycle_t        cycle_i,
	input  dev_sel_t          device_i,
	input  logic [DATA_W-1:0] read_data_i,
	input  logic [DATA_W-1:0] pic_data_i,
	input  logic [DATA_W-1:0] pit_data_i,
	input  logic [DATA_W-1:0] ppi_data_i,
	input  logic [DATA_W-1:0] ram_data_i,
	output logic [DATA_W-1:0] data_bus_o,
	output logic              data_drive_o
);

	logic [DATA_W-1:0] next_data;
	logic              next_drive;
	logic              io_rd;
	logic              mem_rd;

	assign io_rd  = (cycle_i == CYC_IO_RD);
	assign mem_rd = (cycle_i == CYC_MEM_RD);

	// fixed read priority
	always_comb begin
		next_drive = 1'b1;
		next_data  = 8'h00;
		if (cycle_i == CYC_INTA)
			// vector byte from the interrupt controller
			next_data = pic_data_i;
		else if (io_rd && (device_i == DEV_PIC))
			next_data = pic_data_i;
		else if (io_rd && (device_i == DEV_PIT))
			next_data = pit_data_i;
		else if (io_rd && (device_i == DEV_PPI))
			next_data = ppi_data_i;
		else if (io_rd && (device_i == DEV_LPT))
			next_data = read_data_i;
		else if (mem_rd && (device_i == DEV_VRAM))
			next_data = read_data_i;
		else if (mem_rd && (device_i == DEV_RAM))
			next_data = ram_data_i;
		else if (mem_rd)
			next_data = OPEN_BUS;
		else
			next_drive = 1'b0;
	end

	// edge 3, cpu data bus and its enable
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			data_bus_o   <= 8'h00;
			data_drive_o <= 1'b0;
		end else begin
			data_bus_o   <= next_data;
			data_drive_o <= next_drive;
		end
	end

endmodule

`default_nettype wire

// ==== design/system_board_glue.sv ====
`timescale 1ns/10ps
`default_nettype none

module system_board_glue
	import isa_bus_pkg::*;
(
	input  logic              clock,
	input  logic              reset,
	input  logic              peripheral_clock_i,
	input  logic [2:0]        timer_out_i,
	input  logic [DATA_W-1:0] port_b_i,
	input  logic              keyboard_irq_i,
	input  logic [DATA_W-1:0] keycode_i,
	input  logic [7:0]        irq_request_i,
	output logic              timer_clock_o,
	output logic              timer2_gate_o,
	output logic              speaker_o,
	output logic [7:0]        irq_o,
	output logic [DATA_W-1:0] port_a_o
);

	logic [1:0]        pclk_sync;
	logic              pclk_prev;
	logic              pclk_rise;
	logic [1:0]        kbd_irq_sync;
	logic [DATA_W-1:0] keycode_q;

	// peripheral clock into our domain, then one more for edge detect
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			pclk_sync <= 2'b00;
			pclk_prev <= 1'b0;
		end else begin
			pclk_sync <= {pclk_sync[0], peripheral_clock_i};
			pclk_prev <= pclk_sync[1];
		end
	end

	assign pclk_rise = pclk_sync[1] & ~pclk_prev;

	// half the peripheral clock for the pit
	always_ff @(posedge clock or posedge reset) begin
		if (reset)
			timer_clock_o <= 1'b0;
		else if (pclk_rise)
			timer_clock_o <= ~timer_clock_o;
	end

	// port b bit 0 gates counter 2, bit 1 enables the speaker
	assign timer2_gate_o = port_b_i[0];
	assign speaker_o     = timer_out_i[2] & port_b_i[1];

	// keyboard irq and keycode, two flops each
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			kbd_irq_sync <= 2'b00;
			keycode_q    <= 8'h00;
			port_a_o     <= 8'h00;
		end else begin
			kbd_irq_sync <= {kbd_irq_sync[0], keyboard_irq_i};
			keycode_q    <= keycode_i;
			port_a_o     <= keycode_q;
		end
	end

	// irq0 timer, irq1 keyboard, rest from the slots
	// counter 1 is refresh only, not wired here
	assign irq_o = {irq_request_i[7:2], kbd_irq_sync[1], timer_out_i[0]};

endmodule

`default_nettype wire

// ==== design/xt_chipset_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module xt_chipset_top
	import isa_bus_pkg::*;
	import io_map_pkg::*;
#(
	parameter int VRAM_AW = 14
) (
	input  logic              clock,
	input  logic              reset,
	// cpu bus
	input  logic [ADDR_W-1:0] address_i,
	input  logic [DATA_W-1:0] data_i,
	input  logic              io_read_n_i,
	input  logic              io_write_n_i,
	input  logic              memory_read_n_i,
	input  logic              memory_write_n_i,
	input  logic              address_enable_n_i,
	input  logic              interrupt_acknowledge_n_i,
	output logic [DATA_W-1:0] data_bus_o,
	output logic              data_drive_o,
	// external chip selects
	output logic              dma_cs_n_o,
	output logic              dma_page_cs_n_o,
	output logic              pic_cs_n_o,
	output logic              pit_cs_n_o,
	output logic              ppi_cs_n_o,
	// read data from external chips and system ram
	input  logic [DATA_W-1:0] pic_data_i,
	input  logic [DATA_W-1:0] pit_data_i,
	input  logic [DATA_W-1:0] ppi_data_i,
	input  logic [DATA_W-1:0] ram_data_i,
	// timer, speaker, keyboard, interrupts
	input  logic              peripheral_clock_i,
	input  logic [2:0]        timer_out_i,
	input  logic [DATA_W-1:0] port_b_i,
	input  logic              keyboard_irq_i,
	input  logic [DATA_W-1:0] keycode_i,
	input  logic [7:0]        irq_request_i,
	output logic              timer_clock_o,
	output logic              timer2_gate_o,
	output logic              speaker_o,
	output logic [7:0]        irq_o,
	output logic [DATA_W-1:0] port_a_o
);

	// decode to access
	bus_cycle_t         dec_cycle;
	dev_sel_t           dec_device;
	logic [VRAM_AW-1:0] dec_address;
	logic [DATA_W-1:0]  dec_data;

	// access to return
	bus_cycle_t         acc_cycle;
	dev_sel_t           acc_device;
	logic [DATA_W-1:0]  acc_read_data;

	bus_decode_stage #(
		.VRAM_AW(VRAM_AW)
	) u_decode (
		.clock                    (clock),
		.reset                    (reset),
		.address_i                (address_i),
		.data_i                   (data_i),
		.io_read_n_i              (io_read_n_i),
		.io_write_n_i             (io_write_n_i),
		.memory_read_n_i          (memory_read_n_i),
		.memory_write_n_i         (memory_write_n_i),
		.address_enable_n_i       (address_enable_n_i),
		.interrupt_acknowledge_n_i(interrupt_acknowledge_n_i),
		.dma_cs_n_o               (dma_cs_n_o),
		.dma_page_cs_n_o          (dma_page_cs_n_o),
		.pic_cs_n_o               (pic_cs_n_o),
		.pit_cs_n_o               (pit_cs_n_o),
		.ppi_cs_n_o               (ppi_cs_n_o),
		.cycle_o                  (dec_cycle),
		.device_o                 (dec_device),
		.address_o                (dec_address),
		.data_o                   (dec_data)
	);

	device_access_stage #(
		.VRAM_AW(VRAM_AW)
	) u_access (
		.clock      (clock),
		.reset      (reset),
		.cycle_i    (dec_cycle),
		.device_i   (dec_device),
		.address_i  (dec_address),
		.data_i     (dec_data),
		.cycle_o    (acc_cycle),
		.device_o   (acc_device),
		.read_data_o(acc_read_data)
	);

	read_return_stage u_return (
		.clock       (clock),
		.reset       (reset),
		.cycle_i     (acc_cycle),
		.device_i    (acc_device),
		.read_data_i (acc_read_data),
		.pic_data_i  (pic_data_i),
		.pit_data_i  (pit_data_i),
		.ppi_data_i  (ppi_data_i),
		.ram_data_i  (ram_data_i),
		.data_bus_o  (data_bus_o),
		.data_drive_o(data_drive_o)
	);

	system_board_glue u_glue (
		.clock             (clock),
		.reset             (reset),
		.peripheral_clock_i(peripheral_clock_i),
		.timer_out_i       (timer_out_i),
		.port_b_i          (port_b_i),
		.keyboard_irq_i    (keyboard_irq_i),
		.keycode_i         (keycode_i),
		.irq_request_i     (irq_request_i),
		.timer_clock_o     (timer_clock_o),
		.timer2_gate_o     (timer2_gate_o),
		.speaker_o         (speaker_o),
		.irq_o             (irq_o),
		.port_a_o          (port_a_o)
	);

endmodule

`default_nettype wire

// ==== test/xt_chipset_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module xt_chipset_tb;

	localparam int VRAM_AW = 14;
	// vram near 1040 cycles plus timer 800 plus latch 260 plus under 100 for the rest
	// limit about twice the whole run
	localparam int TIMEOUT_CYCLES = 5000;

	// active low strobes as {inta, mem_wr, mem_rd, io_wr, io_rd}
	localparam logic [4:0] S_IDLE     = 5'b11111;
	localparam logic [4:0] S_IOR      = 5'b11110;
	localparam logic [4:0] S_IOW      = 5'b11101;
	localparam logic [4:0] S_MEMR     = 5'b11011;
	localparam logic [4:0] S_MEMW     = 5'b10111;
	localparam logic [4:0] S_INTA     = 5'b01111;
	localparam logic [4:0] S_INTA_IOR = 5'b01110;

	logic        clock;
	logic        reset;
	logic [19:0] address;
	logic [7:0]  wdata;
	logic        io_read_n;
	logic        io_write_n;
	logic        memory_read_n;
	logic        memory_write_n;
	logic        address_enable_n;
	logic        interrupt_acknowledge_n;
	logic [7:0]  data_bus;
	logic        data_drive;
	logic        dma_cs_n;
	logic        dma_page_cs_n;
	logic        pic_cs_n;
	logic        pit_cs_n;
	logic        ppi_cs_n;
	logic [7:0]  pic_data;
	logic [7:0]  pit_data;
	logic [7:0]  ppi_data;
	logic [7:0]  ram_data;
	logic        peripheral_clock;
	logic [2:0]  timer_out;
	logic [7:0]  port_b;
	logic        keyboard_irq;
	logic [7:0]  keycode;
	logic [7:0]  irq_request;
	logic        timer_clock;
	logic        timer2_gate;
	logic        speaker;
	logic [7:0]  irq;
	logic [7:0]  port_a;

	logic [31:0] rng_state;
	int          cycle_count = 0;
	int          check_count = 0;
	int          error_count = 0;
	int          test_count = 0;
	int          errors_at_start = 0;
	string       test_name;
	// expected {drive, data} per bus step in issue order
	logic [8:0]  expect_q[$];
	string       label_q[$];
	// reference copies of the latch and video ram
	logic [7:0]  latch_model;
	logic [7:0]  vram_model [2**VRAM_AW];

	xt_chipset_top #(
		.VRAM_AW(VRAM_AW)
	) dut (
		.clock                    (clock),
		.reset                    (reset),
		.address_i                (address),
		.data_i                   (wdata),
		.io_read_n_i              (io_read_n),
		.io_write_n_i             (io_write_n),
		.memory_read_n_i          (memory_read_n),
		.memory_write_n_i         (memory_write_n),
		.address_enable_n_i       (address_enable_n),
		.interrupt_acknowledge_n_i(interrupt_acknowledge_n),
		.data_bus_o               (data_bus),
		.data_drive_o             (data_drive),
		.dma_cs_n_o               (dma_cs_n),
		.dma_page_cs_n_o          (dma_page_cs_n),
		.pic_cs_n_o               (pic_cs_n),
		.pit_cs_n_o               (pit_cs_n),
		.ppi_cs_n_o               (ppi_cs_n),
		.pic_data_i               (pic_data),
		.pit_data_i               (pit_data),
		.ppi_data_i               (ppi_data),
		.ram_data_i               (ram_data),
		.peripheral_clock_i       (peripheral_clock),
		.timer_out_i              (timer_out),
		.port_b_i                 (port_b),
		.keyboard_irq_i           (keyboard_irq),
		.keycode_i                (keycode),
		.irq_request_i            (irq_request),
		.timer_clock_o            (timer_clock),
		.timer2_gate_o            (timer2_gate),
		.speaker_o                (speaker),
		.irq_o                    (irq),
		.port_a_o                 (port_a)
	);

	// 4 ns clock
	always #2 clock = ~clock;

	// run limit
	always @(posedge clock) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	// xorshift32
	function automatic logic [31:0] next_random();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	function automatic logic [7:0] random_byte();
		logic [31:0] r;
		r = next_random();
		return r[7:0];
	endfunction

	task automatic check_value(input string label, input logic [31:0] expected,
			input logic [31:0] actual);
		check_count++;
		if (expected !== actual) begin
			error_count++;
			$display("Fail %s (%s): expected 0x%0h, actual 0x%0h",
				test_name, label, expected, actual);
		end
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		test_count++;
		errors_at_start = error_count;
	endtask

	task automatic end_test();
		if (error_count == errors_at_start)
			$display("%s: ok", test_name);
		else
			$display("%s: %0d errors", test_name, error_count - errors_at_start);
	endtask

	// inputs change 1 ns after the edge
	task automatic tick();
		@(posedge clock);
		#1;
	endtask

	// result of the step driven three ticks back
	task automatic check_oldest();
		logic [8:0] expected;
		string      label;
		expected = expect_q.pop_front();
		label    = label_q.pop_front();
		check_value(label, 32'(expected), 32'({data_drive, data_bus}));
	endtask

	// one bus state per cycle with its response queued for three edges later
	task automatic bus_step(input string label, input logic [4:0] strobes_n,
			input logic aen_n, input logic [19:0] addr, input logic [7:0] data,
			input logic exp_drive, input logic [7:0] exp_data);
		tick();
		if (expect_q.size() >= 3)
			check_oldest();
		{interrupt_acknowledge_n, memory_write_n, memory_read_n, io_write_n, io_read_n} =
			strobes_n;
		address_enable_n = aen_n;
		address          = addr;
		wdata            = data;
		expect_q.push_back({exp_drive, exp_data});
		label_q.push_back(label);
	endtask

	// idle bus until every queued response is checked
	task automatic drain_pipeline();
		while (expect_q.size() > 0) begin
			tick();
			check_oldest();
			{interrupt_acknowledge_n, memory_write_n, memory_read_n, io_write_n, io_read_n} =
				S_IDLE;
		end
	endtask

	task automatic test_chip_selects();
		logic [8:0] exp;
		logic [4:0] sel_expected;
		begin_test("chip_selects");
		for (int i = 0; i < 5; i++) begin
			// only pic, pit and ppi answer an io read
			case (i)
				1:       exp = {1'b1, pic_data};
				2:       exp = {1'b1, pit_data};
				3:       exp = {1'b1, ppi_data};
				default: exp = 9'h000;
			endcase
			bus_step("board read", S_IOR, 1'b0, 20'(i * 32 + 5), 8'h00, exp[8], exp[7:0]);
			#1;
			sel_expected = ~(5'b00001 << i);
			check_value("select", 32'(sel_expected),
				32'({dma_page_cs_n, ppi_cs_n, pit_cs_n, pic_cs_n, dma_cs_n}));
		end
		// dma owns the bus
		bus_step("aen high", S_IOR, 1'b1, 20'h00020, 8'h00, 1'b0, 8'h00);
		#1;
		check_value("select aen", 32'h1F,
			32'({dma_page_cs_n, ppi_cs_n, pit_cs_n, pic_cs_n, dma_cs_n}));
		bus_step("high port", S_IOR, 1'b0, 20'h00120, 8'h00, 1'b0, 8'h00);
		#1;
		check_value("select a9:8", 32'h1F,
			32'({dma_page_cs_n, ppi_cs_n, pit_cs_n, pic_cs_n, dma_cs_n}));
		bus_step("memory read", S_MEMR, 1'b0, 20'h00020, 8'h00, 1'b1, ram_data);
		#1;
		check_value("select mem", 32'h1F,
			32'({dma_page_cs_n, ppi_cs_n, pit_cs_n, pic_cs_n, dma_cs_n}));
		drain_pipeline();
		end_test();
	endtask

	task automatic test_printer_latch();
		logic [7:0] value;
		begin_test("printer_latch");
		bus_step("reset value", S_IOR, 1'b0, 20'h00378, 8'h00, 1'b1, latch_model);
		// each write directly followed by its read
		repeat (128) begin
			value = random_byte();
			bus_step("write", S_IOW, 1'b0, 20'h00378, value, 1'b0, 8'h00);
			latch_model = value;
			bus_step("read back", S_IOR, 1'b0, 20'h00378, 8'h00, 1'b1, latch_model);
		end
		drain_pipeline();
		end_test();
	endtask

	task automatic test_video_ram();
		logic [31:0]        r;
		logic [VRAM_AW-1:0] offset;
		logic [VRAM_AW-1:0] offsets[$];
		logic [7:0]         value;
		begin_test("video_ram");
		repeat (512) begin
			r      = next_random();
			offset = r[VRAM_AW-1:0];
			value  = r[31:24];
			vram_model[offset] = value;
			offsets.push_back(offset);
			bus_step("write", S_MEMW, 1'b0, 20'hB8000 + 20'(offset), value, 1'b0, 8'h00);
		end
		// back to back reads with three in flight
		while (offsets.size() > 0) begin
			offset = offsets.pop_front();
			bus_step("read back", S_MEMR, 1'b0, 20'hB8000 + 20'(offset), 8'h00, 1'b1,
				vram_model[offset]);
		end
		// system ram below 80000h
		repeat (8) begin
			r = next_random();
			bus_step("ram read", S_MEMR, 1'b0, r[19:0] & 20'h7FFFF, 8'h00, 1'b1, ram_data);
		end
		bus_step("open bus", S_MEMR, 1'b0, 20'hC0000, 8'h00, 1'b1, 8'hFF);
		drain_pipeline();
		end_test();
	endtask

	task automatic test_read_priority();
		begin_test("read_priority");
		bus_step("inta", S_INTA, 1'b0, 20'h00000, 8'h00, 1'b1, pic_data);
		// inta beats the io read of the pit
		bus_step("inta over io", S_INTA_IOR, 1'b0, 20'h00040, 8'h00, 1'b1, pic_data);
		bus_step("pic read", S_IOR, 1'b0, 20'h00020, 8'h00, 1'b1, pic_data);
		bus_step("pit read", S_IOR, 1'b0, 20'h00040, 8'h00, 1'b1, pit_data);
		bus_step("ppi read", S_IOR, 1'b0, 20'h00060, 8'h00, 1'b1, ppi_data);
		bus_step("idle", S_IDLE, 1'b0, 20'h00060, 8'h00, 1'b0, 8'h00);
		drain_pipeline();
		end_test();
	endtask

	task automatic test_timer_speaker();
		int   toggles;
		logic last;
		begin_test("timer_speaker");
		toggles = 0;
		last    = timer_clock;
		// 20 peripheral periods of 40 cycles whose long low tail covers the settling
		for (int n = 0; n < 800; n++) begin
			tick();
			if (timer_clock !== last)
				toggles++;
			last = timer_clock;
			peripheral_clock = ((n % 40) < 20);
		end
		check_value("timer toggles", 32'd20, 32'(toggles));
		// counter 2 output against both port b bits
		for (int c = 0; c < 8; c++) begin
			tick();
			timer_out = {c[2], 2'b00};
			port_b    = {6'b101010, c[1], c[0]};
			#1;
			check_value("speaker", 32'(c[2] & c[1]), 32'(speaker));
			check_value("gate", 32'(c[0]), 32'(timer2_gate));
		end
		end_test();
	endtask

	task automatic test_keyboard_irq();
		logic [7:0] value;
		logic [7:0] old_keycode;
		begin_test("keyboard_irq");
		value       = random_byte();
		old_keycode = keycode;
		tick();
		keycode      = value;
		keyboard_irq = 1'b1;
		tick();
		check_value("port a early", 32'(old_keycode), 32'(port_a));
		check_value("irq1 early", 32'd0, 32'(irq[1]));
		tick();
		check_value("port a", 32'(value), 32'(port_a));
		check_value("irq1", 32'd1, 32'(irq[1]));
		keyboard_irq = 1'b0;
		tick();
		tick();
		check_value("irq1 clear", 32'd0, 32'(irq[1]));
		// straight through lines
		irq_request = random_byte();
		timer_out   = 3'b001;
		#1;
		check_value("irq 7:2", 32'(irq_request[7:2]), 32'(irq[7:2]));
		check_value("irq0", 32'(timer_out[0]), 32'(irq[0]));
		// irq0 low while the other timer outputs are high
		timer_out = 3'b110;
		#1;
		check_value("irq0 low", 32'(timer_out[0]), 32'(irq[0]));
		end_test();
	endtask

	initial begin
		rng_state               = 32'ha3ce_de84;
		clock                   = 1'b0;
		reset                   = 1'b1;
		address                 = 20'h00000;
		wdata                   = 8'h00;
		io_read_n               = 1'b1;
		io_write_n              = 1'b1;
		memory_read_n           = 1'b1;
		memory_write_n          = 1'b1;
		address_enable_n        = 1'b1;
		interrupt_acknowledge_n = 1'b1;
		// external chips hold one value each
		pic_data                = random_byte();
		pit_data                = random_byte();
		ppi_data                = random_byte();
		ram_data                = random_byte();
		peripheral_clock        = 1'b0;
		timer_out               = 3'b000;
		port_b                  = 8'h00;
		keyboard_irq            = 1'b0;
		keycode                 = 8'h00;
		irq_request             = 8'h00;
		latch_model             = 8'hFF;
		repeat (5) @(posedge clock);
		#1;
		reset = 1'b0;

		test_chip_selects();
		test_printer_latch();
		test_video_ram();
		test_read_priority();
		test_timer_speaker();
		test_keyboard_irq();

		$display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
		if (error_count == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== xt_chipset.f ====
design/isa_bus_pkg.sv
design/io_map_pkg.sv
design/bus_decode_stage.sv
design/device_access_stage.sv
design/read_return_stage.sv
design/system_board_glue.sv
design/xt_chipset_top.sv
test/xt_chipset_tb.sv

// ==== Makefile ====
TOOL      = verilator
FLAGS     = --binary --timing
TOP       = xt_chipset_tb
FILE_LIST = xt_chipset.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: simulate clean

simulate:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILE_LIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
